// File: nbody_pkg.sv
// Shared widths, vector types, bus region codes, bus structs
// and the run sequencer state type
package nbody_pkg;

    // Bus and datapath widths
    localparam int EXT_W    = 32;
    localparam int DATA_W   = 64;
    localparam int ADDR_W   = 16;
    localparam int BODY_W   = 9;
    localparam int REGION_W = 7;

    typedef logic [EXT_W-1:0]    ext_word_t;
    typedef logic [DATA_W-1:0]   word_t;
    typedef logic [BODY_W-1:0]   body_idx_t;
    typedef logic [REGION_W-1:0] region_t;

    // Control registers
    localparam region_t REG_GO       = 7'h00;
    localparam region_t REG_N_BODIES = 7'h02;
    localparam region_t REG_GAP      = 7'h03;

    // Memory write windows, LO half first then HI half
    localparam region_t X_LO  = 7'h04;
    localparam region_t X_HI  = 7'h05;
    localparam region_t Y_LO  = 7'h06;
    localparam region_t Y_HI  = 7'h07;
    localparam region_t VX_LO = 7'h0A;
    localparam region_t VX_HI = 7'h0B;
    localparam region_t VY_LO = 7'h0C;
    localparam region_t VY_HI = 7'h0D;

    // Read-back windows
    localparam region_t RD_DONE = 7'h40;
    localparam region_t RD_X_LO = 7'h41;
    localparam region_t RD_X_HI = 7'h42;
    localparam region_t RD_Y_LO = 7'h43;
    localparam region_t RD_Y_HI = 7'h44;

    // Software write into one axis lane
    typedef struct packed {
        logic      pos_we;
        logic      vel_we;
        body_idx_t body;
        word_t     data;
    } lane_wr_t;

    // One body handed to the lanes for update
    typedef struct packed {
        logic      valid;
        body_idx_t body;
    } step_issue_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        ISSUE = 2'd1,
        DRAIN = 2'd2
    } seq_state_e;

endpackage

// File: body_ram.sv
// Per-body word memory with one write port and a registered read port
module body_ram (
    input  logic                 clk,
    input  logic                 we_i,
    input  nbody_pkg::body_idx_t waddr_i,
    input  nbody_pkg::word_t     wdata_i,
    input  nbody_pkg::body_idx_t raddr_i,
    output nbody_pkg::word_t     rdata_o
);

    localparam int DEPTH = 1 << nbody_pkg::BODY_W;

    nbody_pkg::word_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i] <= wdata_i;
        end
    end

    // Old data on a same-address read and write
    always_ff @(posedge clk) begin
        rdata_o <= mem[raddr_i];
    end

endmodule

// File: axis_lane.sv
// One axis of the integrator: position and velocity memories,
// pipelined position + velocity adder and the write-back path
module axis_lane #(
    parameter int ADD_LATENCY = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  nbody_pkg::lane_wr_t    sw_wr_i,
    input  logic                   busy_i,
    input  nbody_pkg::step_issue_t issue_i,
    input  nbody_pkg::body_idx_t   rd_body_i,
    output nbody_pkg::word_t       pos_o
);

    nbody_pkg::word_t     pos_rd;
    nbody_pkg::word_t     vel_rd;
    nbody_pkg::step_issue_t rd_q;

    // Adder pipeline, one entry per stage
    nbody_pkg::word_t     sum_q  [ADD_LATENCY];
    nbody_pkg::body_idx_t body_q [ADD_LATENCY];
    logic [ADD_LATENCY-1:0] valid_q;

    logic                 pos_we;
    nbody_pkg::body_idx_t pos_waddr;
    nbody_pkg::word_t     pos_wdata;
    nbody_pkg::body_idx_t pos_raddr;
    logic                 vel_we;

    // Run owns the memories, otherwise software does
    always_comb begin
        if (busy_i) begin
            pos_we    = valid_q[ADD_LATENCY-1];
            pos_waddr = body_q[ADD_LATENCY-1];
            pos_wdata = sum_q[ADD_LATENCY-1];
            pos_raddr = issue_i.body;
        end else begin
            pos_we    = sw_wr_i.pos_we;
            pos_waddr = sw_wr_i.body;
            pos_wdata = sw_wr_i.data;
            pos_raddr = rd_body_i;
        end
    end

    assign vel_we = sw_wr_i.vel_we & ~busy_i;

    body_ram pos_ram (
        .clk     (clk),
        .we_i    (pos_we),
        .waddr_i (pos_waddr),
        .wdata_i (pos_wdata),
        .raddr_i (pos_raddr),
        .rdata_o (pos_rd)
    );

    body_ram vel_ram (
        .clk     (clk),
        .we_i    (vel_we),
        .waddr_i (sw_wr_i.body),
        .wdata_i (sw_wr_i.data),
        .raddr_i (issue_i.body),
        .rdata_o (vel_rd)
    );

    // Issue delayed to line up with the RAM outputs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_q    <= '0;
            valid_q <= '0;
        end else begin
            rd_q       <= issue_i;
            valid_q[0] <= rd_q.valid;
            for (int i = 1; i < ADD_LATENCY; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Sum formed in the first stage, then carried with its body index
    always_ff @(posedge clk) begin
        sum_q[0]  <= pos_rd + vel_rd;
        body_q[0] <= rd_q.body;
        for (int i = 1; i < ADD_LATENCY; i++) begin
            sum_q[i]  <= sum_q[i-1];
            body_q[i] <= body_q[i-1];
        end
    end

    assign pos_o = pos_rd;

endmodule

// File: step_sequencer.sv
// Run control FSM: body issue counter, drain wait after each step,
// step counter and the busy and done flags
module step_sequencer #(
    parameter int ADD_LATENCY = 4
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   start_i,
    input  nbody_pkg::body_idx_t   n_bodies_i,
    input  nbody_pkg::body_idx_t   gap_i,
    output nbody_pkg::step_issue_t issue_o,
    output logic                   busy_o,
    output logic                   done_o
);

    localparam int DRAIN_W = $clog2(ADD_LATENCY + 2);

    nbody_pkg::seq_state_e state_q;
    nbody_pkg::body_idx_t  body_cnt_q;
    nbody_pkg::body_idx_t  step_cnt_q;
    logic [DRAIN_W-1:0]    drain_cnt_q;
    logic                  done_q;

    nbody_pkg::body_idx_t  last_body;
    nbody_pkg::body_idx_t  last_step;
    logic                  drain_end;

    assign last_body = n_bodies_i - 1'b1;

    // Gap of zero still runs one step
    assign last_step = (gap_i == '0) ? '0 : gap_i - 1'b1;

    // Drain covers the adder depth plus the RAM read cycle
    assign drain_end = (drain_cnt_q == DRAIN_W'(ADD_LATENCY));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state_q     <= nbody_pkg::IDLE;
            body_cnt_q  <= '0;
            step_cnt_q  <= '0;
            drain_cnt_q <= '0;
            done_q      <= 1'b0;
        end else begin
            case (state_q)
                nbody_pkg::IDLE: begin
                    if (start_i) begin
                        body_cnt_q  <= '0;
                        step_cnt_q  <= '0;
                        drain_cnt_q <= '0;
                        if (n_bodies_i == '0) begin
                            // Nothing to move
                            done_q <= 1'b1;
                        end else begin
                            done_q  <= 1'b0;
                            state_q <= nbody_pkg::ISSUE;
                        end
                    end
                end

                nbody_pkg::ISSUE: begin
                    if (body_cnt_q == last_body) begin
                        drain_cnt_q <= '0;
                        state_q     <= nbody_pkg::DRAIN;
                    end else begin
                        body_cnt_q <= body_cnt_q + 1'b1;
                    end
                end

                nbody_pkg::DRAIN: begin
                    if (!drain_end) begin
                        drain_cnt_q <= drain_cnt_q + 1'b1;
                    end else if (step_cnt_q == last_step) begin
                        done_q  <= 1'b1;
                        state_q <= nbody_pkg::IDLE;
                    end else begin
                        step_cnt_q <= step_cnt_q + 1'b1;
                        body_cnt_q <= '0;
                        state_q    <= nbody_pkg::ISSUE;
                    end
                end

                default: state_q <= nbody_pkg::IDLE;
            endcase
        end
    end

    assign issue_o.valid = (state_q == nbody_pkg::ISSUE);
    assign issue_o.body  = body_cnt_q;
    assign busy_o        = (state_q != nbody_pkg::IDLE);
    assign done_o        = done_q;

endmodule

// File: bus_regs.sv
// Bus decode, N_BODIES and GAP registers, lower-half latch,
// lane write requests and the one-cycle read port
module bus_regs (
    input  logic                            clk,
    input  logic                            rst,
    input  nbody_pkg::ext_word_t            writedata_i,
    input  logic [nbody_pkg::ADDR_W-1:0]    addr_i,
    input  logic                            read_i,
    input  logic                            write_i,
    input  logic                            chipselect_i,
    input  logic                            busy_i,
    input  logic                            done_i,
    input  nbody_pkg::word_t                x_pos_i,
    input  nbody_pkg::word_t                y_pos_i,
    output nbody_pkg::ext_word_t            readdata_o,
    output nbody_pkg::lane_wr_t             x_wr_o,
    output nbody_pkg::lane_wr_t             y_wr_o,
    output nbody_pkg::body_idx_t            rd_body_o,
    output logic                            start_o,
    output nbody_pkg::body_idx_t            n_bodies_o,
    output nbody_pkg::body_idx_t            gap_o
);

    localparam int EXT_W  = nbody_pkg::EXT_W;
    localparam int DATA_W = nbody_pkg::DATA_W;
    localparam int BODY_W = nbody_pkg::BODY_W;

    nbody_pkg::region_t   region;
    nbody_pkg::body_idx_t body;
    logic                 wr_en;
    logic                 sw_wr;
    logic                 lo_hit;
    nbody_pkg::ext_word_t lo_q;
    nbody_pkg::word_t     wr_word;
    nbody_pkg::body_idx_t n_bodies_q;
    nbody_pkg::body_idx_t gap_q;
    logic                 rd_pend_q;
    nbody_pkg::region_t   rd_region_q;

    assign region = addr_i[nbody_pkg::ADDR_W-1:BODY_W];
    assign body   = addr_i[BODY_W-1:0];
    assign wr_en  = chipselect_i & write_i;

    // Writes allowed only between runs
    assign sw_wr   = wr_en & ~busy_i;
    assign lo_hit  = (region == nbody_pkg::X_LO)  || (region == nbody_pkg::Y_LO) ||
                     (region == nbody_pkg::VX_LO) || (region == nbody_pkg::VY_LO);
    assign wr_word = {writedata_i, lo_q};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            n_bodies_q <= '0;
            gap_q      <= '0;
        end else if (sw_wr) begin
            if (region == nbody_pkg::REG_N_BODIES) begin
                n_bodies_q <= writedata_i[BODY_W-1:0];
            end
            if (region == nbody_pkg::REG_GAP) begin
                gap_q <= writedata_i[BODY_W-1:0];
            end
        end
    end

    // Lower half waits here for its HI write
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lo_q <= '0;
        end else if (sw_wr && lo_hit) begin
            lo_q <= writedata_i;
        end
    end

    always_comb begin
        x_wr_o.pos_we = sw_wr && (region == nbody_pkg::X_HI);
        x_wr_o.vel_we = sw_wr && (region == nbody_pkg::VX_HI);
        x_wr_o.body   = body;
        x_wr_o.data   = wr_word;
        y_wr_o.pos_we = sw_wr && (region == nbody_pkg::Y_HI);
        y_wr_o.vel_we = sw_wr && (region == nbody_pkg::VY_HI);
        y_wr_o.body   = body;
        y_wr_o.data   = wr_word;
    end

    assign start_o    = sw_wr && (region == nbody_pkg::REG_GO) && writedata_i[0];
    assign n_bodies_o = n_bodies_q;
    assign gap_o      = gap_q;

    // Both lanes look up the addressed body, answer comes next cycle
    assign rd_body_o = body;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_pend_q   <= 1'b0;
            rd_region_q <= '0;
        end else begin
            rd_pend_q   <= chipselect_i & read_i;
            rd_region_q <= region;
        end
    end

    always_comb begin
        readdata_o = '0;
        if (rd_pend_q) begin
            case (rd_region_q)
                nbody_pkg::RD_DONE: readdata_o = {{(EXT_W-1){1'b0}}, done_i};
                nbody_pkg::RD_X_LO: readdata_o = x_pos_i[EXT_W-1:0];
                nbody_pkg::RD_X_HI: readdata_o = x_pos_i[DATA_W-1:EXT_W];
                nbody_pkg::RD_Y_LO: readdata_o = y_pos_i[EXT_W-1:0];
                nbody_pkg::RD_Y_HI: readdata_o = y_pos_i[DATA_W-1:EXT_W];
                default:            readdata_o = '1;
            endcase
        end
    end

endmodule

// File: nbody_top.sv
// Integrator top: bus block, run sequencer and the X and Y lanes
module nbody_top #(
    parameter int ADD_LATENCY = 4
) (
    input  logic                         clk,
    input  logic                         rst,
    input  nbody_pkg::ext_word_t         writedata_i,
    input  logic [nbody_pkg::ADDR_W-1:0] addr_i,
    input  logic                         read_i,
    input  logic                         write_i,
    input  logic                         chipselect_i,
    output nbody_pkg::ext_word_t         readdata_o
);

    nbody_pkg::lane_wr_t    x_wr;
    nbody_pkg::lane_wr_t    y_wr;
    nbody_pkg::step_issue_t issue;
    nbody_pkg::body_idx_t   rd_body;
    nbody_pkg::body_idx_t   n_bodies;
    nbody_pkg::body_idx_t   gap;
    nbody_pkg::word_t       x_pos;
    nbody_pkg::word_t       y_pos;
    logic                   start;
    logic                   busy;
    logic                   done;

    bus_regs u_bus (
        .clk          (clk),
        .rst          (rst),
        .writedata_i  (writedata_i),
        .addr_i       (addr_i),
        .read_i       (read_i),
        .write_i      (write_i),
        .chipselect_i (chipselect_i),
        .busy_i       (busy),
        .done_i       (done),
        .x_pos_i      (x_pos),
        .y_pos_i      (y_pos),
        .readdata_o   (readdata_o),
        .x_wr_o       (x_wr),
        .y_wr_o       (y_wr),
        .rd_body_o    (rd_body),
        .start_o      (start),
        .n_bodies_o   (n_bodies),
        .gap_o        (gap)
    );

    step_sequencer #(
        .ADD_LATENCY (ADD_LATENCY)
    ) u_seq (
        .clk        (clk),
        .rst        (rst),
        .start_i    (start),
        .n_bodies_i (n_bodies),
        .gap_i      (gap),
        .issue_o    (issue),
        .busy_o     (busy),
        .done_o     (done)
    );

    // Both axes share the issue stream
    axis_lane #(
        .ADD_LATENCY (ADD_LATENCY)
    ) lane_x (
        .clk       (clk),
        .rst       (rst),
        .sw_wr_i   (x_wr),
        .busy_i    (busy),
        .issue_i   (issue),
        .rd_body_i (rd_body),
        .pos_o     (x_pos)
    );

    axis_lane #(
        .ADD_LATENCY (ADD_LATENCY)
    ) lane_y (
        .clk       (clk),
        .rst       (rst),
        .sw_wr_i   (y_wr),
        .busy_i    (busy),
        .issue_i   (issue),
        .rd_body_i (rd_body),
        .pos_o     (y_pos)
    );

endmodule

// File: tb_nbody.sv
// Testbench for the n-body integrator: replays the command file
// against the top level and checks every bus read
module tb_nbody;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ADD_LATENCY = 4;
    localparam logic [15:0] GO_ADDR   = {nbody_pkg::REG_GO, 9'd0};
    localparam logic [15:0] DONE_ADDR = {nbody_pkg::RD_DONE, 9'd0};

    logic                         clk;
    logic                         rst;
    nbody_pkg::ext_word_t         writedata;
    logic [nbody_pkg::ADDR_W-1:0] addr;
    logic                         read;
    logic                         write;
    logic                         chipselect;
    nbody_pkg::ext_word_t         readdata;

    // Commands as parsed from the data file
    byte         cmd_op   [$];
    logic [15:0] cmd_addr [$];
    logic [31:0] cmd_data [$];

    int cycle_cnt   = 0;
    int cycle_limit = 0;
    int n_checks    = 0;
    int n_mismatch  = 0;
    int n_other     = 0;

    nbody_top #(
        .ADD_LATENCY (ADD_LATENCY)
    ) dut0 (
        .clk          (clk),
        .rst          (rst),
        .writedata_i  (writedata),
        .addr_i       (addr),
        .read_i       (read),
        .write_i      (write),
        .chipselect_i (chipselect),
        .readdata_o   (readdata)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic print_counts();
        $display("checks %0d, mismatches %0d, other errors %0d",
                 n_checks, n_mismatch, n_other);
    endtask

    task automatic load_commands();
        int          fd;
        int          n;
        int          line_no;
        string       line;
        byte         op;
        logic [31:0] a;
        logic [31:0] d;
        line_no = 0;
        fd = $fopen("nbody_tests.txt", "r");
        if (fd == 0) begin
            $display("error: cannot open nbody_tests.txt");
            n_other++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            a    = '0;
            d    = '0;
            n    = $fgets(line, fd);
            line_no++;
            if (n > 0 && line.getc(0) != "#") begin
                n = $sscanf(line, "%c %h %h", op, a, d);
                if (op == "G") begin
                    cmd_op.push_back(op);
                    cmd_addr.push_back(16'h0);
                    cmd_data.push_back(32'h0);
                end else if ((op == "W" || op == "R") && n == 3) begin
                    cmd_op.push_back(op);
                    cmd_addr.push_back(a[15:0]);
                    cmd_data.push_back(d);
                end else if (op == "W" || op == "R") begin
                    $display("error: line %0d of the command file is malformed", line_no);
                    n_other++;
                end
            end
        end
        $fclose(fd);
    endtask

    // All bus tasks start and end 2 ns after a rising edge
    task automatic bus_write(input logic [15:0] a, input logic [31:0] d);
        addr       = a;
        writedata  = d;
        write      = 1'b1;
        chipselect = 1'b1;
        @(posedge clk);
        #2;
        write      = 1'b0;
        chipselect = 1'b0;
    endtask

    task automatic bus_read(input logic [15:0] a, output logic [31:0] d);
        addr       = a;
        read       = 1'b1;
        chipselect = 1'b1;
        @(posedge clk);
        #2;
        read       = 1'b0;
        chipselect = 1'b0;
        // Data is valid for the whole cycle after the request
        @(negedge clk);
        d = readdata;
        @(posedge clk);
        #2;
    endtask

    task automatic check_read(input logic [15:0] a, input logic [31:0] exp);
        logic [31:0] got;
        bus_read(a, got);
        n_checks++;
        if (got !== exp) begin
            n_mismatch++;
            $display("mismatch at %0d ns: readdata_o expected %h, got %h (addr %h)",
                     $time, exp, got, a);
        end
    endtask

    task automatic start_and_wait();
        logic [31:0] status;
        bus_write(GO_ADDR, 32'h1);
        status = '0;
        while (status[0] !== 1'b1) begin
            bus_read(DONE_ADDR, status);
        end
    endtask

    // Watchdog on the cycle counter
    initial begin
        wait (cycle_limit > 0);
        wait (cycle_cnt >= cycle_limit);
        $display("error: the command file did not finish within %0d cycles", cycle_limit);
        n_other++;
        print_counts();
        $display("Simulation failed");
        $finish;
    end

    initial begin
        writedata  = '0;
        addr       = '0;
        read       = 1'b0;
        write      = 1'b0;
        chipselect = 1'b0;
        rst        = 1'b1;
        load_commands();
        if (cmd_op.size() == 0) begin
            $display("error: no commands were loaded");
            n_other++;
        end else begin
            // Worst case per command is a full run of 512 bodies
            cycle_limit = cmd_op.size() * (512 * (ADD_LATENCY + 2) + 50);
        end
        repeat (10) @(posedge clk);
        #2;
        rst = 1'b0;
        for (int i = 0; i < cmd_op.size(); i++) begin
            case (cmd_op[i])
                "W":     bus_write(cmd_addr[i], cmd_data[i]);
                "R":     check_read(cmd_addr[i], cmd_data[i]);
                default: start_and_wait();
            endcase
        end
        print_counts();
        if (n_mismatch == 0 && n_other == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: nbody_tests.txt
# Columns: cmd addr data, in hex. W is a bus write, R a bus read with expected data,
# G writes GO and polls DONE. The address is region << 9 | body
R 8000 00000000
R FE00 FFFFFFFF
R 0200 FFFFFFFF
# HI writes reuse the lower half latched by the last LO write
W 0800 FFFFFFFF
W 0A00 00000001
W 1A00 FFFFFFFF
W 1A01 FFFFFFFF
W 1A02 FFFFFFFF
W 1400 00000001
W 1600 00000000
W 1601 00000000
W 1602 00000000
W 0C00 00000010
W 0E00 00000000
W 0E01 00000000
W 0E02 00000000
W 0A01 00000003
W 0A02 00000000
W 0A07 00000000
W 0E07 00000000
W 1607 00000000
W 1A07 00000000
R 8200 FFFFFFFF
R 8400 00000001
R 8600 00000010
R 8800 00000000
R 8401 00000003
# Three bodies, one step, carry into X0 high half, Y moves by -1
W 0400 00000003
W 0600 00000001
G
R 8000 00000001
R 8200 00000000
R 8400 00000002
R 8600 0000000F
R 8800 00000000
R 8201 00000011
R 8401 00000003
R 8202 00000011
R 8602 0000000F
R 8207 00000010
# Eight bodies, five steps, DONE drops at start
W 0400 00000008
W 0600 00000005
W 0000 00000001
R 8000 00000000
G
R 8200 00000005
R 8400 00000002
R 8600 0000000A
R 8201 00000016
R 8207 00000060
R 8607 00000060
# Writes while busy are dropped, N stays 8
W 0600 00000001
W 0000 00000001
W 0800 00000000
W 0A00 12345678
W 0400 00000002
G
R 8200 00000006
R 8400 00000002
G
R 8200 00000007
R 8207 00000080
# Zero bodies leaves positions alone
W 0400 00000000
G
R 8000 00000001
R 8200 00000007
R 8600 00000008
R 8607 00000080

// File: filelist.f
nbody_pkg.sv
body_ram.sv
axis_lane.sv
step_sequencer.sv
bus_regs.sv
nbody_top.sv
tb_nbody.sv
